//--- rtl/tcb_arbiter.sv
`timescale 1ns/1ns

`include "tcb_consts.svh"

module tcb_arbiter (
    input  logic            tcb,
    input  logic            reset,
    // manager 0
    input  logic            m0_vld,
    input  logic            m0_wen,
    input  tcb_pkg::adr_t   m0_adr,
    input  tcb_pkg::ben_t   m0_ben,
    input  tcb_pkg::dat_t   m0_wdt,
    output logic            m0_rdy,
    output tcb_pkg::dat_t   m0_rdt,
    output logic            m0_err,
    // manager 1
    input  logic            m1_vld,
    input  logic            m1_wen,
    input  tcb_pkg::adr_t   m1_adr,
    input  tcb_pkg::ben_t   m1_ben,
    input  tcb_pkg::dat_t   m1_wdt,
    output logic            m1_rdy,
    output tcb_pkg::dat_t   m1_rdt,
    output logic            m1_err,
    // shared bus toward the decoder
    output logic            bus_vld,
    output logic            bus_wen,
    output tcb_pkg::adr_t   bus_adr,
    output tcb_pkg::ben_t   bus_ben,
    output tcb_pkg::dat_t   bus_wdt,
    input  logic            bus_rdy,
    input  tcb_pkg::dat_t   bus_rdt,
    input  logic            bus_err
);

    // manager that wins a tie
    tcb_pkg::mgr_t pri;

    logic          gnt0;
    logic          gnt1;
    tcb_pkg::mgr_t sel;
    logic          trn;

    // owner of each transfer still waiting for its response
    logic [`TCB_DLY-1:0] own_vld;
    tcb_pkg::mgr_t       own_idx [`TCB_DLY];

    logic rsp0;
    logic rsp1;

////////////////////
// grant
////////////////////

    // lone requester wins at once, a tie goes to pri
    assign gnt0 = m0_vld && (!m1_vld || (pri == 1'b0));
    assign gnt1 = m1_vld && (!m0_vld || (pri == 1'b1));

    assign sel = tcb_pkg::mgr_t'(gnt1);

    // rdy drops only while the other side holds the grant
    assign m0_rdy = bus_rdy && !gnt1;
    assign m1_rdy = bus_rdy && !gnt0;

    // request mux
    assign bus_vld = m0_vld || m1_vld;
    assign bus_wen = (sel == 1'b1) ? m1_wen : m0_wen;
    assign bus_adr = (sel == 1'b1) ? m1_adr : m0_adr;
    assign bus_ben = (sel == 1'b1) ? m1_ben : m0_ben;
    assign bus_wdt = (sel == 1'b1) ? m1_wdt : m0_wdt;

    assign trn = bus_vld && bus_rdy;

    // after a transfer the loser gets the next tie
    always_ff @(posedge tcb) begin
        if (reset) begin
            pri <= 1'b0;
        end else if (trn) begin
            pri <= ~sel;
        end
    end

////////////////////
// response routing
////////////////////

    // owner valid bits are control state
    always_ff @(posedge tcb) begin
        if (reset) begin
            own_vld <= '0;
        end else begin
            own_vld[0] <= trn;
            for (int i = 1; i < `TCB_DLY; i++) begin
                own_vld[i] <= own_vld[i-1];
            end
        end
    end

    // owner index only matters where own_vld is set
    always_ff @(posedge tcb) begin
        own_idx[0] <= sel;
        for (int i = 1; i < `TCB_DLY; i++) begin
            own_idx[i] <= own_idx[i-1];
        end
    end

    // last stage lines up with the response slot
    assign rsp0 = own_vld[`TCB_DLY-1] && (own_idx[`TCB_DLY-1] == 1'b0);
    assign rsp1 = own_vld[`TCB_DLY-1] && (own_idx[`TCB_DLY-1] == 1'b1);

    // the idle manager sees a quiet response
    assign m0_rdt = rsp0 ? bus_rdt : '0;
    assign m0_err = rsp0 && bus_err;
    assign m1_rdt = rsp1 ? bus_rdt : '0;
    assign m1_err = rsp1 && bus_err;

////////////////////
// checks
////////////////////

    a_gnt_excl: assert property (@(posedge tcb) disable iff (reset)
        !(gnt0 && gnt1));

    // a driven bus always has a single winning requester behind it
    a_gnt_one: assert property (@(posedge tcb) disable iff (reset)
        bus_vld |-> $onehot({gnt0 && m0_vld, gnt1 && m1_vld}));

endmodule : tcb_arbiter

//--- rtl/tcb_consts.svh
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

////////////////////
// bus widths
////////////////////

// byte address width
`define TCB_ADR 16
// data word width
`define TCB_DAT 32
// one enable per data byte
`define TCB_BYT (`TCB_DAT/8)

////////////////////
// timing and map
////////////////////

// cycles from the transfer edge to the response slot, at least 1
`define TCB_DLY 1

// memory region in bytes, base must be word aligned
`define TCB_MEM_BASE 16'h0000
`define TCB_MEM_SIZE 16'h0400

`endif

//--- rtl/tcb_decoder.sv
`timescale 1ns/1ns

`include "tcb_consts.svh"

module tcb_decoder (
    input  logic            tcb,
    input  logic            reset,
    // bus from the arbiter
    input  logic            bus_vld,
    input  logic            bus_wen,
    input  tcb_pkg::adr_t   bus_adr,
    input  tcb_pkg::ben_t   bus_ben,
    input  tcb_pkg::dat_t   bus_wdt,
    output logic            bus_rdy,
    output tcb_pkg::dat_t   bus_rdt,
    output logic            bus_err,
    // memory subordinate
    output logic            mem_vld,
    output logic            mem_wen,
    output tcb_pkg::adr_t   mem_adr,
    output tcb_pkg::ben_t   mem_ben,
    output tcb_pkg::dat_t   mem_wdt,
    input  logic            mem_rdy,
    input  tcb_pkg::dat_t   mem_rdt,
    input  logic            mem_err,
    // error subordinate
    output logic            err_vld,
    output tcb_pkg::adr_t   err_adr,
    input  logic            err_rdy,
    input  tcb_pkg::dat_t   err_rdt,
    input  logic            err_err
);

    tcb_map_pkg::region_t region;
    logic                 trn;

    // region of each transfer in flight
    tcb_map_pkg::region_t reg_dly [`TCB_DLY];
    tcb_map_pkg::region_t rsp_reg;

////////////////////
// request steering
////////////////////

    assign region = tcb_map_pkg::decode(bus_adr);

    // only the addressed subordinate sees vld
    assign mem_vld = bus_vld && (region == tcb_map_pkg::REGION_MEM);
    assign err_vld = bus_vld && (region == tcb_map_pkg::REGION_ERR);

    // payload fans out unchanged
    assign mem_wen = bus_wen;
    assign mem_adr = bus_adr;
    assign mem_ben = bus_ben;
    assign mem_wdt = bus_wdt;
    assign err_adr = bus_adr;

    // ready comes back from the selected side
    assign bus_rdy = (region == tcb_map_pkg::REGION_MEM) ? mem_rdy : err_rdy;

    assign trn = bus_vld && bus_rdy;

////////////////////
// response select
////////////////////

    // idle slots park on memory, which answers zero when idle
    always_ff @(posedge tcb) begin
        if (reset) begin
            for (int i = 0; i < `TCB_DLY; i++) begin
                reg_dly[i] <= tcb_map_pkg::REGION_MEM;
            end
        end else begin
            reg_dly[0] <= trn ? region : tcb_map_pkg::REGION_MEM;
            for (int i = 1; i < `TCB_DLY; i++) begin
                reg_dly[i] <= reg_dly[i-1];
            end
        end
    end

    assign rsp_reg = reg_dly[`TCB_DLY-1];

    assign bus_rdt = (rsp_reg == tcb_map_pkg::REGION_ERR) ? err_rdt : mem_rdt;
    assign bus_err = (rsp_reg == tcb_map_pkg::REGION_ERR) ? err_err : mem_err;

////////////////////
// checks
////////////////////

    a_mem_region: assert property (@(posedge tcb) disable iff (reset)
        mem_vld |-> (tcb_map_pkg::decode(mem_adr) == tcb_map_pkg::REGION_MEM));

    a_err_region: assert property (@(posedge tcb) disable iff (reset)
        err_vld |-> (tcb_map_pkg::decode(err_adr) == tcb_map_pkg::REGION_ERR));

endmodule : tcb_decoder

//--- rtl/tcb_error_subordinate.sv
`timescale 1ns/1ns

`include "tcb_consts.svh"

module tcb_error_subordinate (
    input  logic            tcb,
    input  logic            reset,
    input  logic            vld,
    input  logic            wen,
    input  tcb_pkg::adr_t   adr,
    output logic            rdy,
    output tcb_pkg::dat_t   rdt,
    output logic            err,
    // bus fault record
    output tcb_pkg::adr_t   fault_adr,
    output logic            fault_vld
);

    logic                trn;
    logic [`TCB_DLY-1:0] err_dly;

    // accepts anything, returns nothing
    assign rdy = 1'b1;
    assign rdt = '0;

    assign trn = vld && rdy;

    // error marker rides to the response slot
    always_ff @(posedge tcb) begin
        if (reset) begin
            err_dly <= '0;
        end else begin
            err_dly[0] <= trn;
            for (int i = 1; i < `TCB_DLY; i++) begin
                err_dly[i] <= err_dly[i-1];
            end
        end
    end

    assign err = err_dly[`TCB_DLY-1];

    // last faulting address, flag stays set until reset
    always_ff @(posedge tcb) begin
        if (reset) begin
            fault_adr <= '0;
            fault_vld <= 1'b0;
        end else if (trn) begin
            fault_adr <= adr;
            fault_vld <= 1'b1;
        end
    end

    a_err_slot: assert property (@(posedge tcb) disable iff (reset)
        err |-> $past(trn, `TCB_DLY));

    // reads and writes both fault, but the direction must still be known
    a_req_known: assert property (@(posedge tcb) disable iff (reset)
        trn |-> !$isunknown({wen, adr}));

endmodule : tcb_error_subordinate

//--- rtl/tcb_map_pkg.sv
`include "tcb_consts.svh"

package tcb_map_pkg;

    // subordinate selected by an address
    typedef enum logic {
        REGION_MEM,
        REGION_ERR
    } region_t;

    // map a byte address onto its region
    // anything outside the memory window lands on the error subordinate
    function automatic region_t decode(tcb_pkg::adr_t adr);
        tcb_pkg::adr_t off;
        // offset wraps for addresses below the base, so one compare covers both ends
        off = adr - tcb_pkg::adr_t'(`TCB_MEM_BASE);
        if (off < tcb_pkg::adr_t'(`TCB_MEM_SIZE)) begin
            return REGION_MEM;
        end
        return REGION_ERR;
    endfunction : decode

endpackage : tcb_map_pkg

//--- rtl/tcb_memory.sv
`timescale 1ns/1ns

`include "tcb_consts.svh"

module tcb_memory (
    input  logic            tcb,
    input  logic            vld,
    input  logic            wen,
    input  tcb_pkg::adr_t   adr,
    input  tcb_pkg::ben_t   ben,
    input  tcb_pkg::dat_t   wdt,
    output logic            rdy,
    output tcb_pkg::dat_t   rdt,
    output logic            err
);

    // array geometry
    localparam int unsigned WRD = `TCB_MEM_SIZE / `TCB_BYT;
    localparam int unsigned IDW = $clog2(WRD);
    localparam int unsigned BOW = $clog2(`TCB_BYT);

    tcb_pkg::dat_t mem [WRD];

    tcb_pkg::adr_t  off;
    logic [IDW-1:0] idx;
    logic           trn;

    // read data on its way to the response slot
    tcb_pkg::dat_t rdt_dly [`TCB_DLY];

    // never stalls, never faults
    assign rdy = 1'b1;
    assign err = 1'b0;

    assign trn = vld && rdy;

    // word index from the offset inside the window
    assign off = adr - tcb_pkg::adr_t'(`TCB_MEM_BASE);
    assign idx = off[BOW +: IDW];

////////////////////
// array
////////////////////

    // byte lanes are written one by one
    always_ff @(posedge tcb) begin
        if (trn && wen) begin
            for (int b = 0; b < `TCB_BYT; b++) begin
                if (ben[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

////////////////////
// read pipeline
////////////////////

    // writes and idle cycles leave zero in the slot
    always_ff @(posedge tcb) begin
        rdt_dly[0] <= (trn && !wen) ? mem[idx] : '0;
        for (int i = 1; i < `TCB_DLY; i++) begin
            rdt_dly[i] <= rdt_dly[i-1];
        end
    end

    assign rdt = rdt_dly[`TCB_DLY-1];

    // a write with no lane enabled is a manager bug
    a_wr_ben: assert property (@(posedge tcb)
        (trn && wen) |-> (ben != '0));

endmodule : tcb_memory

//--- rtl/tcb_pkg.sv
`include "tcb_consts.svh"

package tcb_pkg;

    // byte address as seen on every bus segment
    typedef logic [`TCB_ADR-1:0] adr_t;

    // write and read data word
    typedef logic [`TCB_DAT-1:0] dat_t;

    // byte enables
    // bit n qualifies data bits 8n+7 down to 8n
    typedef logic [`TCB_BYT-1:0] ben_t;

    // manager index
    // 0 is m0, 1 is m1
    typedef logic mgr_t;

endpackage : tcb_pkg

//--- rtl/tcb_subsystem.sv
`timescale 1ns/1ns

module tcb_subsystem (
    input  logic            tcb,
    input  logic            reset,
    // manager 0
    input  logic            m0_vld,
    input  logic            m0_wen,
    input  tcb_pkg::adr_t   m0_adr,
    input  tcb_pkg::ben_t   m0_ben,
    input  tcb_pkg::dat_t   m0_wdt,
    output logic            m0_rdy,
    output tcb_pkg::dat_t   m0_rdt,
    output logic            m0_err,
    // manager 1
    input  logic            m1_vld,
    input  logic            m1_wen,
    input  tcb_pkg::adr_t   m1_adr,
    input  tcb_pkg::ben_t   m1_ben,
    input  tcb_pkg::dat_t   m1_wdt,
    output logic            m1_rdy,
    output tcb_pkg::dat_t   m1_rdt,
    output logic            m1_err,
    // bus fault record
    output tcb_pkg::adr_t   err_adr,
    output logic            err_vld
);

    // arbiter to decoder
    logic          bus_vld;
    logic          bus_wen;
    tcb_pkg::adr_t bus_adr;
    tcb_pkg::ben_t bus_ben;
    tcb_pkg::dat_t bus_wdt;
    logic          bus_rdy;
    tcb_pkg::dat_t bus_rdt;
    logic          bus_err;

    // decoder to memory
    logic          mem_vld;
    logic          mem_wen;
    tcb_pkg::adr_t mem_adr;
    tcb_pkg::ben_t mem_ben;
    tcb_pkg::dat_t mem_wdt;
    logic          mem_rdy;
    tcb_pkg::dat_t mem_rdt;
    logic          mem_err;

    // decoder to error subordinate
    logic          esb_vld;
    tcb_pkg::adr_t esb_adr;
    logic          esb_rdy;
    tcb_pkg::dat_t esb_rdt;
    logic          esb_err;

    tcb_arbiter u_arb (
        .tcb     (tcb),     .reset   (reset),
        .m0_vld  (m0_vld),  .m0_wen  (m0_wen),  .m0_adr (m0_adr),
        .m0_ben  (m0_ben),  .m0_wdt  (m0_wdt),
        .m0_rdy  (m0_rdy),  .m0_rdt  (m0_rdt),  .m0_err (m0_err),
        .m1_vld  (m1_vld),  .m1_wen  (m1_wen),  .m1_adr (m1_adr),
        .m1_ben  (m1_ben),  .m1_wdt  (m1_wdt),
        .m1_rdy  (m1_rdy),  .m1_rdt  (m1_rdt),  .m1_err (m1_err),
        .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
        .bus_ben (bus_ben), .bus_wdt (bus_wdt),
        .bus_rdy (bus_rdy), .bus_rdt (bus_rdt), .bus_err (bus_err)
    );

    tcb_decoder u_dec (
        .tcb     (tcb),     .reset   (reset),
        .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
        .bus_ben (bus_ben), .bus_wdt (bus_wdt),
        .bus_rdy (bus_rdy), .bus_rdt (bus_rdt), .bus_err (bus_err),
        .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_adr (mem_adr),
        .mem_ben (mem_ben), .mem_wdt (mem_wdt),
        .mem_rdy (mem_rdy), .mem_rdt (mem_rdt), .mem_err (mem_err),
        .err_vld (esb_vld), .err_adr (esb_adr),
        .err_rdy (esb_rdy), .err_rdt (esb_rdt), .err_err (esb_err)
    );

    tcb_memory u_mem (
        .tcb (tcb),
        .vld (mem_vld), .wen (mem_wen), .adr (mem_adr),
        .ben (mem_ben), .wdt (mem_wdt),
        .rdy (mem_rdy), .rdt (mem_rdt), .err (mem_err)
    );

    // direction is taken straight off the shared bus
    tcb_error_subordinate u_esb (
        .tcb       (tcb),     .reset     (reset),
        .vld       (esb_vld), .wen       (bus_wen), .adr (esb_adr),
        .rdy       (esb_rdy), .rdt       (esb_rdt), .err (esb_err),
        .fault_adr (err_adr), .fault_vld (err_vld)
    );

endmodule : tcb_subsystem

//--- tb.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_map_pkg.sv
rtl/tcb_arbiter.sv
rtl/tcb_decoder.sv
rtl/tcb_memory.sv
rtl/tcb_error_subordinate.sv
rtl/tcb_subsystem.sv
tb/tcb_subsystem_tb.sv

//--- tb/tcb_subsystem_tb.sv
`timescale 1ns/1ns

`include "tcb_consts.svh"

module tcb_subsystem_tb;

    localparam int N_ROWS = 14;
    localparam int N_PRE  = 8;
    localparam int N_RND  = 60;
    localparam int WORDS  = `TCB_MEM_SIZE / `TCB_BYT;
    // every transfer costs at most a few cycles plus the response delay
    localparam int LIMIT  = (N_ROWS + N_PRE + 2 * N_RND) * (4 + `TCB_DLY) + 100;

    typedef struct packed {
        tcb_pkg::mgr_t mgr;
        logic          wen;
        tcb_pkg::adr_t adr;
        tcb_pkg::ben_t ben;
        tcb_pkg::dat_t wdt;
        tcb_pkg::dat_t rdt;
        logic          err;
    } row_t;

    // expected response and the edge where it must show up
    typedef struct packed {
        logic [31:0]   due;
        logic          err;
        tcb_pkg::dat_t rdt;
    } rsp_t;

    // mgr, wen, adr, ben, wdt, expected rdt, expected err
    localparam row_t ROWS [N_ROWS] = '{
        '{1'b0, 1'b1, 16'h0010, 4'hF, 32'h11223344, 32'h00000000, 1'b0},
        '{1'b0, 1'b0, 16'h0010, 4'hF, 32'h00000000, 32'h11223344, 1'b0},
        '{1'b1, 1'b1, 16'h0010, 4'h5, 32'hAABBCCDD, 32'h00000000, 1'b0},
        '{1'b1, 1'b0, 16'h0010, 4'hF, 32'h00000000, 32'h11BB33DD, 1'b0},
        '{1'b0, 1'b1, 16'h0010, 4'h8, 32'hEE000000, 32'h00000000, 1'b0},
        '{1'b0, 1'b0, 16'h0010, 4'hF, 32'h00000000, 32'hEEBB33DD, 1'b0},
        '{1'b1, 1'b1, 16'h03FC, 4'hF, 32'hCAFEF00D, 32'h00000000, 1'b0},
        '{1'b0, 1'b1, 16'h03FC, 4'h2, 32'h00005A00, 32'h00000000, 1'b0},
        '{1'b1, 1'b0, 16'h03FC, 4'hF, 32'h00000000, 32'hCAFE5A0D, 1'b0},
        '{1'b0, 1'b1, 16'h0410, 4'hF, 32'h12345678, 32'h00000000, 1'b1},
        '{1'b1, 1'b0, 16'h8000, 4'hF, 32'h00000000, 32'h00000000, 1'b1},
        '{1'b0, 1'b0, 16'h0010, 4'hF, 32'h00000000, 32'hEEBB33DD, 1'b0},
        '{1'b1, 1'b0, 16'hFFFC, 4'hF, 32'h00000000, 32'h00000000, 1'b1},
        '{1'b0, 1'b0, 16'h03FC, 4'hF, 32'h00000000, 32'hCAFE5A0D, 1'b0}
    };

    logic                      tcb;
    logic                      reset;
    logic [1:0]                vld;
    logic [1:0]                wen;
    logic [1:0][`TCB_ADR-1:0]  adr;
    logic [1:0][`TCB_BYT-1:0]  ben;
    logic [1:0][`TCB_DAT-1:0]  wdt;
    wire  [1:0]                rdy;
    wire  [1:0]                err;
    wire  [1:0][`TCB_DAT-1:0]  rdt;
    wire  [`TCB_ADR-1:0]       fault_adr;
    wire                       fault_vld;

    int            cyc = 0;
    rsp_t          exp_q0 [$];
    rsp_t          exp_q1 [$];
    tcb_pkg::dat_t ref_mem [WORDS];
    tcb_pkg::adr_t last_fault;
    logic          last_win = 1'b1;
    logic [1:0]    stall = '0;

    tcb_subsystem uut (
        .tcb    (tcb),    .reset  (reset),
        .m0_vld (vld[0]), .m0_wen (wen[0]), .m0_adr (adr[0]),
        .m0_ben (ben[0]), .m0_wdt (wdt[0]),
        .m0_rdy (rdy[0]), .m0_rdt (rdt[0]), .m0_err (err[0]),
        .m1_vld (vld[1]), .m1_wen (wen[1]), .m1_adr (adr[1]),
        .m1_ben (ben[1]), .m1_wdt (wdt[1]),
        .m1_rdy (rdy[1]), .m1_rdt (rdt[1]), .m1_err (err[1]),
        .err_adr (fault_adr), .err_vld (fault_vld)
    );

    initial tcb = 1'b0;
    always #4 tcb = ~tcb;

    // cycle count doubles as the time base for response slots
    always @(posedge tcb) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout: run still busy after %0d cycles", LIMIT);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

////////////////////
// helpers
////////////////////

    task automatic abort_run(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "check failed");
    endtask

    // fields change after the rising edge this is called on
    task automatic present(input int m, input logic w, input tcb_pkg::adr_t a,
                           input tcb_pkg::ben_t b, input tcb_pkg::dat_t d);
        vld[m] <= 1'b1;
        wen[m] <= w;
        adr[m] <= a;
        ben[m] <= b;
        wdt[m] <= d;
    endtask

    // returns on the edge where vld and rdy are both high
    task automatic await_handshake(input int m, output int waited);
        waited = 0;
        @(posedge tcb);
        while (!(vld[m] && rdy[m])) begin
            waited++;
            @(posedge tcb);
        end
    endtask

    // reference model update on the handshake edge
    task automatic predict(input logic w, input tcb_pkg::adr_t a, input tcb_pkg::ben_t b,
                           input tcb_pkg::dat_t d, output rsp_t r);
        int idx;
        r.due = 32'(cyc + `TCB_DLY);
        r.err = 1'b0;
        r.rdt = '0;
        if (tcb_map_pkg::decode(a) == tcb_map_pkg::REGION_ERR) begin
            r.err = 1'b1;
            last_fault = a;
        end else begin
            idx = int'(a - tcb_pkg::adr_t'(`TCB_MEM_BASE)) / `TCB_BYT;
            if (w) begin
                for (int i = 0; i < `TCB_BYT; i++) begin
                    if (b[i]) ref_mem[idx][8*i +: 8] = d[8*i +: 8];
                end
            end else begin
                r.rdt = ref_mem[idx];
            end
        end
    endtask

    task automatic push_expected(input int m, input rsp_t r);
        if (m == 0) begin
            exp_q0.push_back(r);
        end else begin
            exp_q1.push_back(r);
        end
    endtask

    // owner gets its response in the slot while everyone else stays quiet
    task automatic check_slot(input int m, input logic e, input tcb_pkg::dat_t d);
        rsp_t r;
        int   cnt;
        cnt = (m == 0) ? exp_q0.size() : exp_q1.size();
        r = '0;
        if (cnt > 0) r = (m == 0) ? exp_q0[0] : exp_q1[0];
        if (cnt > 0 && r.due == 32'(cyc)) begin
            assert (e == r.err && d == r.rdt) else abort_run($sformatf(
                "m%0d response err=%b rdt=%h, expected err=%b rdt=%h", m, e, d, r.err, r.rdt));
            if (m == 0) void'(exp_q0.pop_front());
            else void'(exp_q1.pop_front());
        end else begin
            assert (e == 1'b0 && d == '0) else abort_run($sformatf(
                "m%0d response outside its slot err=%b rdt=%h", m, e, d));
        end
    endtask

    // a tie goes to the manager that lost the last transfer
    task automatic check_arbitration();
        if (vld[0] && vld[1]) begin
            assert (rdy[0] != rdy[1]) else abort_run("tie did not grant exactly one manager");
            assert (rdy[last_win] == 1'b0) else abort_run("tie went to the last winner");
        end
        for (int m = 0; m < 2; m++) begin
            if (vld[m] && !rdy[m]) begin
                assert (stall[m] == 1'b0) else abort_run($sformatf(
                    "m%0d waited more than one transfer", m));
                stall[m] = 1'b1;
            end else begin
                stall[m] = 1'b0;
            end
        end
        if (vld[0] && rdy[0]) last_win = 1'b0;
        else if (vld[1] && rdy[1]) last_win = 1'b1;
    endtask

    always @(posedge tcb) begin
        if (!reset) begin
            check_slot(0, err[0], rdt[0]);
            check_slot(1, err[1], rdt[1]);
            check_arbitration();
        end
    end

////////////////////
// random traffic
////////////////////

    // back to back requests keep vld high between them
    task automatic run_random(input int m);
        logic          w;
        tcb_pkg::adr_t a;
        tcb_pkg::ben_t b;
        tcb_pkg::dat_t d;
        rsp_t          r;
        int            waited;
        for (int n = 0; n < N_RND; n++) begin
            w = 1'($urandom_range(1, 0));
            b = tcb_pkg::ben_t'($urandom_range(15, 1));
            d = $urandom;
            if ($urandom_range(3, 0) == 0) begin
                // aligned address that falls outside the memory window
                do begin
                    a = tcb_pkg::adr_t'($urandom) & ~tcb_pkg::adr_t'(3);
                end while (tcb_map_pkg::decode(a) != tcb_map_pkg::REGION_ERR);
            end else begin
                a = tcb_pkg::adr_t'(`TCB_MEM_BASE + 4 * $urandom_range(N_PRE - 1, 0));
            end
            present(m, w, a, b, d);
            await_handshake(m, waited);
            predict(w, a, b, d, r);
            push_expected(m, r);
        end
        vld[m] <= 1'b0;
    endtask

////////////////////
// main sequence
////////////////////

    initial begin
        row_t          row;
        rsp_t          r;
        int            waited;
        tcb_pkg::adr_t a;
        void'($urandom(32'had97));
        reset = 1'b1;
        vld = '0;
        wen = '0;
        adr = '0;
        ben = '0;
        wdt = '0;
        repeat (3) @(posedge tcb);
        reset <= 1'b0;
        @(posedge tcb);
        assert (fault_vld == 1'b0 && fault_adr == '0)
            else abort_run("fault record not clear after reset");

        // directed rows with one lone requester at a time
        for (int i = 0; i < N_ROWS; i++) begin
            row = ROWS[i];
            present(row.mgr, row.wen, row.adr, row.ben, row.wdt);
            await_handshake(row.mgr, waited);
            assert (waited == 0) else abort_run("lone requester was not ready at once");
            r.due = 32'(cyc + `TCB_DLY);
            r.err = row.err;
            r.rdt = row.rdt;
            push_expected(row.mgr, r);
            if (row.err) last_fault = row.adr;
            vld[row.mgr] <= 1'b0;
            repeat (`TCB_DLY) @(posedge tcb);
        end
        assert (fault_vld == 1'b1 && fault_adr == last_fault)
            else abort_run($sformatf("fault record %b/%h after table", fault_vld, fault_adr));

        // full word fill so random reads never see unwritten data
        for (int i = 0; i < N_PRE; i++) begin
            a = tcb_pkg::adr_t'(`TCB_MEM_BASE + 4 * i);
            present(0, 1'b1, a, '1, {~a, a});
            await_handshake(0, waited);
            predict(1'b1, a, '1, {~a, a}, r);
            push_expected(0, r);
        end

        fork
            run_random(0);
            run_random(1);
        join

        while (exp_q0.size() + exp_q1.size() > 0) @(posedge tcb);
        assert (fault_vld == 1'b1 && fault_adr == last_fault)
            else abort_run($sformatf("fault address %h, expected %h", fault_adr, last_fault));

        $display("Regression passed");
        $finish;
    end

endmodule : tcb_subsystem_tb
